/* ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Datapath width of the execute stage
`define EX_XLEN 32

// Register file address width
`define EX_RADDR_W 5

// Number of 32-bit words in the control and status block
`define EX_NCSR 4

// Multiplier bits consumed per cycle
// XLEN / MUL_STEP gives the cycle count of one product
`define EX_MUL_STEP 8

`endif

/* ex_pkg.sv */
`include "ex_defs.svh"

package ex_pkg;

  // Operation code, one space for ALU and multiplier
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9,
    OP_EQ   = 4'd10,
    // Low and high word of the 64-bit product
    OP_MUL  = 4'd11,
    OP_MULH = 4'd12
  } ex_op_e;

  // Which block produces the write-back value
  // NONE is a branch-only operation, no write-back
  typedef enum logic [1:0] {
    KIND_ALU  = 2'd0,
    KIND_MULT = 2'd1,
    KIND_CSR  = 2'd2,
    KIND_NONE = 2'd3
  } ex_kind_e;

  // Word index inside the control and status block
  typedef enum logic [1:0] {
    CSR_SCRATCH0 = 2'd0,
    CSR_SCRATCH1 = 2'd1,
    CSR_CTRL     = 2'd2,
    CSR_RETIRED  = 2'd3
  } csr_idx_e;

  // Control word, reserved bits read as zero
  typedef struct packed {
    logic [`EX_XLEN-2:0] rsvd;
    logic                mul_signed;
  } ctrl_t;

endpackage

/* ex_unit_if.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

// Link between the execute stage and one functional unit
interface ex_unit_if;

  // Request side, driven by the stage
  logic                en;
  ex_pkg::ex_op_e      op;
  logic [`EX_XLEN-1:0] op_a;
  logic [`EX_XLEN-1:0] op_b;

  // Response side, driven by the unit
  logic [`EX_XLEN-1:0] result;
  logic                cmp;
  logic                ready;

  modport stage (
    output en, op, op_a, op_b,
    input  result, cmp, ready
  );

  modport unit (
    input  en, op, op_a, op_b,
    output result, cmp, ready
  );

endinterface

/* ex_alu.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_alu (
  // Clock and reset unused since the ALU holds no state
  input  logic    clk,
  input  logic    rst_n,
  ex_unit_if.unit unit_p
);

  localparam int SHW = $clog2(`EX_XLEN);

  logic [SHW-1:0]      shamt;
  logic                lt_s;
  logic                lt_u;
  logic                eq;
  logic                cmp;
  logic [`EX_XLEN-1:0] res;

  // Shift amount from the low bits of operand b
  assign shamt = unit_p.op_b[SHW-1:0];

  // Comparators shared by the set and branch operations
  assign lt_s = $signed(unit_p.op_a) < $signed(unit_p.op_b);
  assign lt_u = unit_p.op_a < unit_p.op_b;
  assign eq   = unit_p.op_a == unit_p.op_b;

  always_comb begin
    cmp = 1'b0;
    case (unit_p.op)
      ex_pkg::OP_SLT:  cmp = lt_s;
      ex_pkg::OP_SLTU: cmp = lt_u;
      ex_pkg::OP_EQ:   cmp = eq;
      default:         cmp = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    res = '0;
    case (unit_p.op)
      ex_pkg::OP_ADD: res = unit_p.op_a + unit_p.op_b;
      ex_pkg::OP_SUB: res = unit_p.op_a - unit_p.op_b;
      ex_pkg::OP_AND: res = unit_p.op_a & unit_p.op_b;
      ex_pkg::OP_OR:  res = unit_p.op_a | unit_p.op_b;
      ex_pkg::OP_XOR: res = unit_p.op_a ^ unit_p.op_b;
      ex_pkg::OP_SLL: res = unit_p.op_a << shamt;
      ex_pkg::OP_SRL: res = unit_p.op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::OP_SRA: res = $signed(unit_p.op_a) >>> shamt;
      // Comparisons write the flag into bit 0
      ex_pkg::OP_SLT,
      ex_pkg::OP_SLTU,
      ex_pkg::OP_EQ:  res = {{(`EX_XLEN-1){1'b0}}, cmp};
      default:        res = '0;
    endcase
  end

  assign unit_p.result = res;

  // Flag only counts when the stage has selected the ALU
  assign unit_p.cmp    = unit_p.en & cmp;

  // Single-cycle unit, never stalls
  assign unit_p.ready  = 1'b1;

endmodule

/* ex_mult.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_mult (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    mul_signed_i,
  ex_unit_if.unit unit_p
);

  localparam int NSTEP = `EX_XLEN / `EX_MUL_STEP;
  localparam int CW    = $clog2(NSTEP);
  localparam int PW    = 2 * `EX_XLEN;

  logic                busy_q;
  logic [CW-1:0]       cnt_q;
  logic                hi_q;
  logic [PW-1:0]       a_q;
  logic [`EX_XLEN-1:0] b_q;
  logic [PW-1:0]       acc_q;
  logic                sgn;
  logic [PW-1:0]       a_ext;
  logic [PW-1:0]       pp;
  logic [PW-1:0]       prod;
  logic                last;

  // Signed operands only for MULH with the control bit set
  assign sgn   = mul_signed_i & (unit_p.op == ex_pkg::OP_MULH);
  assign a_ext = {{`EX_XLEN{sgn & unit_p.op_a[`EX_XLEN-1]}}, unit_p.op_a};

  // Partial product of the shifted multiplicand and the next slice of b
  assign pp    = a_q * b_q[`EX_MUL_STEP-1:0];
  assign prod  = acc_q + pp;

  // Final slice is added combinationally in the last busy cycle
  assign last  = busy_q & (cnt_q == CW'(NSTEP - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      // Start on a request while idle
      if (unit_p.en) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end
    end else if (!last) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (unit_p.en) begin
      // Stage takes the product in this cycle
      busy_q <= 1'b0;
    end
  end

  // Operand and accumulator datapath
  always_ff @(posedge clk) begin
    if (!busy_q) begin
      a_q   <= a_ext;
      b_q   <= unit_p.op_b;
      hi_q  <= unit_p.op == ex_pkg::OP_MULH;
      // Signed b: subtract a * 2^XLEN to undo the unsigned weight of bit 31
      acc_q <= (sgn & unit_p.op_b[`EX_XLEN-1]) ? -(a_ext << `EX_XLEN) : '0;
    end else if (!last) begin
      acc_q <= prod;
      a_q   <= a_q << `EX_MUL_STEP;
      b_q   <= b_q >> `EX_MUL_STEP;
    end
  end

  // Low or high word of the product
  assign unit_p.result = hi_q ? prod[PW-1:`EX_XLEN] : prod[`EX_XLEN-1:0];
  assign unit_p.cmp    = 1'b0;
  // Held high until the stage accepts
  assign unit_p.ready  = last;

endmodule

/* ex_csr_regs.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_csr_regs (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Wishbone classic slave
  input  logic                                 wbs_cyc_i,
  input  logic                                 wbs_stb_i,
  input  logic                                 wbs_we_i,
  input  logic [$clog2(`EX_NCSR)-1:0]          wbs_adr_i,
  input  logic [`EX_XLEN-1:0]                  wbs_dat_i,
  output logic [`EX_XLEN-1:0]                  wbs_dat_o,
  output logic                                 wbs_ack_o,
  // Retire pulse from the stage
  input  logic                                 retire_i,
  output logic [`EX_NCSR-1:0][`EX_XLEN-1:0]    csr_rdata_o,
  output ex_pkg::ctrl_t                        ctrl_o
);

  logic                bus_req;
  logic                bus_wr;
  ex_pkg::csr_idx_e    idx;
  logic [`EX_XLEN-1:0] scratch0_q;
  logic [`EX_XLEN-1:0] scratch1_q;
  logic [`EX_XLEN-1:0] retired_q;
  logic                mul_signed_q;

  // New cycle only while ack is low, so each access acks once
  assign bus_req = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
  assign bus_wr  = bus_req & wbs_we_i;
  assign idx     = ex_pkg::csr_idx_e'(wbs_adr_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbs_ack_o <= 1'b0;
    end else begin
      wbs_ack_o <= bus_req;
    end
  end

  // Read data lands with the ack
  always_ff @(posedge clk) begin
    if (bus_req) begin
      wbs_dat_o <= csr_rdata_o[wbs_adr_i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scratch0_q   <= '0;
      scratch1_q   <= '0;
      mul_signed_q <= 1'b0;
      retired_q    <= '0;
    end else begin
      if (bus_wr && idx == ex_pkg::CSR_SCRATCH0) begin
        scratch0_q <= wbs_dat_i;
      end
      if (bus_wr && idx == ex_pkg::CSR_SCRATCH1) begin
        scratch1_q <= wbs_dat_i;
      end
      if (bus_wr && idx == ex_pkg::CSR_CTRL) begin
        mul_signed_q <= wbs_dat_i[0];
      end
      // Host write clears the counter, any data
      if (bus_wr && idx == ex_pkg::CSR_RETIRED) begin
        retired_q <= '0;
      end else if (retire_i) begin
        retired_q <= retired_q + 1'b1;
      end
    end
  end

  // Control word and read view of all four CSRs
  always_comb begin
    ctrl_o            = '0;
    ctrl_o.mul_signed = mul_signed_q;
    csr_rdata_o[ex_pkg::CSR_SCRATCH0] = scratch0_q;
    csr_rdata_o[ex_pkg::CSR_SCRATCH1] = scratch1_q;
    csr_rdata_o[ex_pkg::CSR_CTRL]     = ctrl_o;
    csr_rdata_o[ex_pkg::CSR_RETIRED]  = retired_q;
  end

endmodule

/* ex_stage.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  // Operation from decode
  input  logic                              op_valid_i,
  input  ex_pkg::ex_kind_e                  op_kind_i,
  input  ex_pkg::ex_op_e                    op_i,
  input  logic [`EX_XLEN-1:0]               operand_a_i,
  input  logic [`EX_XLEN-1:0]               operand_b_i,
  input  ex_pkg::csr_idx_e                  csr_idx_i,
  input  logic [`EX_RADDR_W-1:0]            rf_waddr_i,
  input  logic                              rf_we_i,
  // Control and status block
  input  logic [`EX_NCSR-1:0][`EX_XLEN-1:0] csr_rdata_i,
  input  logic                              mul_signed_i,
  // Back-pressure from write-back
  input  logic                              rf_ready_i,
  // Forwarding to decode
  output logic                              fwd_we_o,
  output logic [`EX_RADDR_W-1:0]            fwd_waddr_o,
  output logic [`EX_XLEN-1:0]               fwd_wdata_o,
  // EX/WB register
  output logic                              rf_we_o,
  output logic [`EX_RADDR_W-1:0]            rf_waddr_o,
  output logic [`EX_XLEN-1:0]               rf_wdata_o,
  output logic                              branch_taken_o,
  output logic                              ex_ready_o,
  output logic                              retire_o
);

  ex_unit_if alu_if ();
  ex_unit_if mult_if ();

  logic                is_mult;
  logic                is_none;
  logic                unit_ready;
  logic                ex_valid;
  logic [`EX_XLEN-1:0] ex_result;

  assign is_mult = op_kind_i == ex_pkg::KIND_MULT;
  assign is_none = op_kind_i == ex_pkg::KIND_NONE;

  // ALU also serves branch-only operations
  assign alu_if.en    = op_valid_i & (op_kind_i == ex_pkg::KIND_ALU | is_none);
  assign alu_if.op    = op_i;
  assign alu_if.op_a  = operand_a_i;
  assign alu_if.op_b  = operand_b_i;

  // Multiplier starts, and releases its result, only when write-back can take it
  assign mult_if.en   = op_valid_i & is_mult & rf_ready_i;
  assign mult_if.op   = op_i;
  assign mult_if.op_a = operand_a_i;
  assign mult_if.op_b = operand_b_i;

  ex_alu alu_inst (
    .clk    ( clk          ),
    .rst_n  ( rst_n        ),
    .unit_p ( alu_if.unit  )
  );

  ex_mult mult_inst (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .mul_signed_i ( mul_signed_i ),
    .unit_p       ( mult_if.unit )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result mux and stall rule
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_kind_i)
      ex_pkg::KIND_ALU:  ex_result = alu_if.result;
      ex_pkg::KIND_MULT: ex_result = mult_if.result;
      ex_pkg::KIND_CSR:  ex_result = csr_rdata_i[csr_idx_i];
      default:           ex_result = '0;
    endcase
  end

  assign unit_ready = is_mult ? mult_if.ready : alu_if.ready;

  // Branches finish without write-back, so they ignore rf_ready_i
  assign ex_ready_o = (unit_ready & rf_ready_i) | is_none;
  assign ex_valid   = op_valid_i & ~is_none & unit_ready & rf_ready_i;
  assign retire_o   = op_valid_i & ex_ready_o;

  assign branch_taken_o = alu_if.cmp;

  // Forwarding path, valid with ex_valid
  assign fwd_we_o    = ex_valid & rf_we_i;
  assign fwd_waddr_o = rf_waddr_i;
  assign fwd_wdata_o = ex_result;

  // EX/WB register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_we_o <= 1'b0;
    end else if (ex_valid) begin
      rf_we_o <= rf_we_i;
    end else if (rf_ready_i) begin
      // Write-back drained with nothing new behind it
      rf_we_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      rf_waddr_o <= rf_waddr_i;
      rf_wdata_o <= ex_result;
    end
  end

endmodule

/* ex_top.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // Operation inputs
  input  logic                          op_valid_i,
  input  ex_pkg::ex_kind_e              op_kind_i,
  input  ex_pkg::ex_op_e                op_i,
  input  logic [`EX_XLEN-1:0]           operand_a_i,
  input  logic [`EX_XLEN-1:0]           operand_b_i,
  input  ex_pkg::csr_idx_e              csr_idx_i,
  input  logic [`EX_RADDR_W-1:0]        rf_waddr_i,
  input  logic                          rf_we_i,
  input  logic                          rf_ready_i,
  // Forwarding and write-back
  output logic                          fwd_we_o,
  output logic [`EX_RADDR_W-1:0]        fwd_waddr_o,
  output logic [`EX_XLEN-1:0]           fwd_wdata_o,
  output logic                          rf_we_o,
  output logic [`EX_RADDR_W-1:0]        rf_waddr_o,
  output logic [`EX_XLEN-1:0]           rf_wdata_o,
  output logic                          branch_taken_o,
  output logic                          ex_ready_o,
  // Host Wishbone port
  input  logic                          wbs_cyc_i,
  input  logic                          wbs_stb_i,
  input  logic                          wbs_we_i,
  input  logic [$clog2(`EX_NCSR)-1:0]   wbs_adr_i,
  input  logic [`EX_XLEN-1:0]           wbs_dat_i,
  output logic [`EX_XLEN-1:0]           wbs_dat_o,
  output logic                          wbs_ack_o
);

  logic [`EX_NCSR-1:0][`EX_XLEN-1:0] csr_rdata;
  ex_pkg::ctrl_t                     ctrl;
  logic                              retire;

  ex_stage ex_stage_inst (
    .clk            ( clk             ),
    .rst_n          ( rst_n           ),
    .op_valid_i     ( op_valid_i      ),
    .op_kind_i      ( op_kind_i       ),
    .op_i           ( op_i            ),
    .operand_a_i    ( operand_a_i     ),
    .operand_b_i    ( operand_b_i     ),
    .csr_idx_i      ( csr_idx_i       ),
    .rf_waddr_i     ( rf_waddr_i      ),
    .rf_we_i        ( rf_we_i         ),
    .csr_rdata_i    ( csr_rdata       ),
    .mul_signed_i   ( ctrl.mul_signed ),
    .rf_ready_i     ( rf_ready_i      ),
    .fwd_we_o       ( fwd_we_o        ),
    .fwd_waddr_o    ( fwd_waddr_o     ),
    .fwd_wdata_o    ( fwd_wdata_o     ),
    .rf_we_o        ( rf_we_o         ),
    .rf_waddr_o     ( rf_waddr_o      ),
    .rf_wdata_o     ( rf_wdata_o      ),
    .branch_taken_o ( branch_taken_o  ),
    .ex_ready_o     ( ex_ready_o      ),
    .retire_o       ( retire          )
  );

  // Control and status block beside the stage
  ex_csr_regs ex_csr_regs_inst (
    .clk         ( clk       ),
    .rst_n       ( rst_n     ),
    .wbs_cyc_i   ( wbs_cyc_i ),
    .wbs_stb_i   ( wbs_stb_i ),
    .wbs_we_i    ( wbs_we_i  ),
    .wbs_adr_i   ( wbs_adr_i ),
    .wbs_dat_i   ( wbs_dat_i ),
    .wbs_dat_o   ( wbs_dat_o ),
    .wbs_ack_o   ( wbs_ack_o ),
    .retire_i    ( retire    ),
    .csr_rdata_o ( csr_rdata ),
    .ctrl_o      ( ctrl      )
  );

endmodule

/* ex_sva.sv */
`timescale 1ns/100ps

// Protocol checks, bound once to the stage and once to the register block
module ex_sva (
  input logic        clk,
  input logic        rst_n,
  input logic        ack,
  input logic        rf_ready,
  input logic        rf_we,
  input logic [4:0]  rf_waddr,
  input logic [31:0] rf_wdata,
  input logic        mult_busy,
  input logic        mult_ready
);

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> !ack)
    else $error("Wishbone ack held for more than one cycle");

  // EX/WB register holds while write-back stalls
  wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!rf_ready && rf_we) |=> $stable(rf_we) && $stable(rf_waddr) && $stable(rf_wdata))
    else $error("EX/WB register changed while rf_ready_i was low");

  // Product ready in the fourth cycle after start
  mult_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mult_busy) |-> !mult_ready [*3] ##1 mult_ready)
    else $error("Multiplier ready not four cycles after start");

endmodule

bind ex_stage ex_sva stage_sva_inst (
  .clk        ( clk                ),
  .rst_n      ( rst_n              ),
  .ack        ( 1'b0               ),
  .rf_ready   ( rf_ready_i         ),
  .rf_we      ( rf_we_o            ),
  .rf_waddr   ( rf_waddr_o         ),
  .rf_wdata   ( rf_wdata_o         ),
  .mult_busy  ( mult_inst.busy_q   ),
  .mult_ready ( mult_inst.last     )
);

bind ex_csr_regs ex_sva csr_sva_inst (
  .clk        ( clk       ),
  .rst_n      ( rst_n     ),
  .ack        ( wbs_ack_o ),
  .rf_ready   ( 1'b1      ),
  .rf_we      ( 1'b0      ),
  .rf_waddr   ( 5'd0      ),
  .rf_wdata   ( 32'd0     ),
  .mult_busy  ( 1'b0      ),
  .mult_ready ( 1'b0      )
);

/* ex_tb.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_tb;

  logic                          clk;
  logic                          rst_n;
  logic                          op_valid_i;
  ex_pkg::ex_kind_e              op_kind_i;
  ex_pkg::ex_op_e                op_i;
  logic [`EX_XLEN-1:0]           operand_a_i;
  logic [`EX_XLEN-1:0]           operand_b_i;
  ex_pkg::csr_idx_e              csr_idx_i;
  logic [`EX_RADDR_W-1:0]        rf_waddr_i;
  logic                          rf_we_i;
  logic                          rf_ready_i;
  logic                          fwd_we_o;
  logic [`EX_RADDR_W-1:0]        fwd_waddr_o;
  logic [`EX_XLEN-1:0]           fwd_wdata_o;
  logic                          rf_we_o;
  logic [`EX_RADDR_W-1:0]        rf_waddr_o;
  logic [`EX_XLEN-1:0]           rf_wdata_o;
  logic                          branch_taken_o;
  logic                          ex_ready_o;
  logic                          wbs_cyc_i;
  logic                          wbs_stb_i;
  logic                          wbs_we_i;
  logic [$clog2(`EX_NCSR)-1:0]   wbs_adr_i;
  logic [`EX_XLEN-1:0]           wbs_dat_i;
  logic [`EX_XLEN-1:0]           wbs_dat_o;
  logic                          wbs_ack_o;

  // Stimulus and back-pressure use separate xorshift streams
  logic [31:0] rng_q;
  logic [31:0] rdy_rng_q;
  logic        bp_en;

  // Model state: pending write-backs as {addr, data}, and a copy of the CSRs
  logic [`EX_RADDR_W+`EX_XLEN-1:0] wb_q[$];
  logic [`EX_XLEN-1:0]             m_scratch0;
  logic [`EX_XLEN-1:0]             m_scratch1;
  logic                            m_mul_signed;
  logic [`EX_XLEN-1:0]             m_retired;

  ex_top ex_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_q = xorshift32(rng_q);
    r = rng_q;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the operation table
  ////////////////////////////////////////////////////////////////////////////

  // Comparison flag, zero for non-compare ops
  function automatic logic cmp_model(input ex_pkg::ex_op_e op, input logic [31:0] a,
                                     input logic [31:0] b);
    case (op)
      ex_pkg::OP_SLT:  return $signed(a) < $signed(b);
      ex_pkg::OP_SLTU: return a < b;
      ex_pkg::OP_EQ:   return a == b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] result_model(input ex_pkg::ex_op_e op, input logic [31:0] a,
                                               input logic [31:0] b, input logic sgn);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        p;
    // Operands widened to 64 bits before the product
    sa = $signed(a);
    sb = $signed(b);
    if (sgn) p = sa * sb;
    else     p = {32'b0, a} * {32'b0, b};
    case (op)
      ex_pkg::OP_ADD:  return a + b;
      ex_pkg::OP_SUB:  return a - b;
      ex_pkg::OP_AND:  return a & b;
      ex_pkg::OP_OR:   return a | b;
      ex_pkg::OP_XOR:  return a ^ b;
      ex_pkg::OP_SLL:  return a << b[4:0];
      ex_pkg::OP_SRL:  return a >> b[4:0];
      ex_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
      ex_pkg::OP_MUL:  return p[31:0];
      ex_pkg::OP_MULH: return p[63:32];
      default:         return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  // Write-back monitor, a held entry counts once when write-back takes it
  always @(negedge clk) begin
    if (rst_n && rf_we_o && rf_ready_i) begin
      if (wb_q.size() == 0) abort_run("Write-back seen with no operation pending");
      check_eq(rf_waddr_o, wb_q[0][`EX_RADDR_W+`EX_XLEN-1:`EX_XLEN], "rf_waddr_o");
      check_eq(rf_wdata_o, wb_q[0][`EX_XLEN-1:0], "rf_wdata_o");
      void'(wb_q.pop_front());
    end
  end

  // Random back-pressure from write-back
  always @(posedge clk) begin
    if (bp_en) begin
      rdy_rng_q = xorshift32(rdy_rng_q);
      rf_ready_i <= rdy_rng_q[1:0] != 2'b00;
    end else begin
      rf_ready_i <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and operation tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int t;
    @(posedge clk);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    wbs_we_i  <= we;
    wbs_adr_i <= adr;
    wbs_dat_i <= wdat;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 20) abort_run("Timeout waiting for Wishbone ack");
    end while (!wbs_ack_o);
    // Ack one cycle after the slave sees the request
    check_eq(t, 2, "Wishbone ack latency");
    rdat = wbs_dat_o;
    @(posedge clk);
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    wbs_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] d);
    logic [31:0] unused;
    wb_access(1'b1, adr, d, unused);
    case (adr)
      2'd0: m_scratch0 = d;
      2'd1: m_scratch1 = d;
      2'd2: m_mul_signed = d[0];
      default: m_retired = '0;
    endcase
  endtask

  task automatic wb_read_check(input logic [1:0] adr, input logic [31:0] exp);
    logic [31:0] r;
    wb_access(1'b0, adr, '0, r);
    check_eq(r, exp, "Wishbone read data");
  endtask

  function automatic logic [31:0] csr_model(input logic [1:0] idx);
    case (idx)
      2'd0:    return m_scratch0;
      2'd1:    return m_scratch1;
      2'd2:    return {31'b0, m_mul_signed};
      default: return m_retired;
    endcase
  endfunction

  // Present one random operation and hold it until the stage accepts
  task automatic run_random_op();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    ex_pkg::ex_kind_e kind;
    ex_pkg::ex_op_e   op;
    logic [1:0] idx;
    logic [4:0] wa;
    logic       we;
    logic       started;
    logic       exp_rdy;
    int t;
    int mcyc;
    next_rand(r);
    kind = r[3:0] < 8 ? ex_pkg::KIND_ALU : r[3:0] < 11 ? ex_pkg::KIND_MULT :
           r[3:0] < 13 ? ex_pkg::KIND_CSR : ex_pkg::KIND_NONE;
    op   = kind == ex_pkg::KIND_MULT ? (r[4] ? ex_pkg::OP_MULH : ex_pkg::OP_MUL) :
           ex_pkg::ex_op_e'(r[11:8] % 11);
    idx  = r[13:12];
    wa   = r[20:16];
    we   = r[23:21] != 3'd0;
    next_rand(a);
    next_rand(b);
    // Equal operands now and then so EQ gets taken
    if (r[27:24] == 4'd0) b = a;
    @(posedge clk);
    op_valid_i  <= 1'b1;
    op_kind_i   <= kind;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    csr_idx_i   <= ex_pkg::csr_idx_e'(idx);
    rf_waddr_i  <= wa;
    rf_we_i     <= we;
    started = 1'b0;
    mcyc = 0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 100) abort_run("Timeout waiting for ex_ready_o");
      // Multiplier starts on the first cycle write-back is ready, done four cycles later
      if (started) mcyc++;
      case (kind)
        ex_pkg::KIND_NONE: exp_rdy = 1'b1;
        ex_pkg::KIND_MULT: exp_rdy = started && mcyc >= 4 && rf_ready_i;
        default:           exp_rdy = rf_ready_i;
      endcase
      check_eq(ex_ready_o, exp_rdy, "ex_ready_o");
      if (!started && rf_ready_i) started = 1'b1;
    end while (!ex_ready_o);
    if (kind == ex_pkg::KIND_CSR) exp = csr_model(idx);
    else exp = result_model(op, a, b, m_mul_signed && op == ex_pkg::OP_MULH);
    if (kind == ex_pkg::KIND_ALU || kind == ex_pkg::KIND_NONE) begin
      check_eq(branch_taken_o, cmp_model(op, a, b), "branch_taken_o");
    end else begin
      check_eq(branch_taken_o, 1'b0, "branch_taken_o");
    end
    if (kind != ex_pkg::KIND_NONE && we) begin
      check_eq(fwd_we_o, 1'b1, "fwd_we_o");
      check_eq(fwd_waddr_o, wa, "fwd_waddr_o");
      check_eq(fwd_wdata_o, exp, "fwd_wdata_o");
      wb_q.push_back({wa, exp});
    end else begin
      check_eq(fwd_we_o, 1'b0, "fwd_we_o");
    end
    m_retired = m_retired + 1;
  endtask

  task automatic stop_ops();
    @(posedge clk);
    op_valid_i <= 1'b0;
  endtask

  task automatic drain_writebacks();
    int t;
    bp_en <= 1'b0;
    t = 0;
    while (wb_q.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > 50) abort_run("Timeout draining pending write-backs");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] d;
    rng_q = 32'h970b_fa08;
    rdy_rng_q = 32'h970b_fa08 ^ 32'h5a5a_a5a5;
    bp_en = 1'b0;
    m_scratch0 = '0;
    m_scratch1 = '0;
    m_mul_signed = 1'b0;
    m_retired = '0;
    rst_n = 1'b0;
    op_valid_i = 1'b0;
    op_kind_i = ex_pkg::KIND_ALU;
    op_i = ex_pkg::OP_ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    csr_idx_i = ex_pkg::CSR_SCRATCH0;
    rf_waddr_i = '0;
    rf_we_i = 1'b0;
    rf_ready_i = 1'b1;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i = 1'b0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Scratch and control registers over the bus
    next_rand(d);
    wb_write(2'd0, d);
    wb_read_check(2'd0, m_scratch0);
    next_rand(d);
    wb_write(2'd1, d);
    wb_read_check(2'd1, m_scratch1);
    wb_write(2'd2, 32'hffff_fff0);
    wb_read_check(2'd2, 32'h0);

    // Unsigned MULH first, then signed
    bp_en <= 1'b1;
    repeat (150) run_random_op();
    stop_ops();
    drain_writebacks();
    wb_write(2'd2, 32'h0000_0001);
    wb_read_check(2'd2, 32'h1);
    bp_en <= 1'b1;
    repeat (150) run_random_op();
    stop_ops();
    drain_writebacks();

    // Retire count, then clear it
    wb_read_check(2'd3, m_retired);
    wb_write(2'd3, 32'h1234_5678);
    wb_read_check(2'd3, 32'h0);

    $display("Regression passed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
ex_pkg.sv
ex_unit_if.sv
ex_alu.sv
ex_mult.sv
ex_csr_regs.sv
ex_stage.sv
ex_top.sv
ex_sva.sv
ex_tb.sv

/* Makefile */
SRCS := ex_defs.svh ex_pkg.sv ex_unit_if.sv ex_alu.sv ex_mult.sv ex_csr_regs.sv \
        ex_stage.sv ex_top.sv ex_sva.sv ex_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vex_tb: $(SRCS) flist.f
	verilator --binary --timing --assert -Wall -f flist.f --top-module ex_tb -Mdir obj_dir

run: obj_dir/Vex_tb
	-./obj_dir/Vex_tb > sim.log 2>&1
	cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
